/* Bender.yml */
package:
  name: doe_top

sources:
  - files:
      - doe_pkg.sv
      - doe_cipher.sv
      - doe_fsm.sv
      - kv_entry.sv
      - kv_read_mux.sv
      - doe_top.sv

  - target: test
    files:
      - tb_clkgen.sv
      - tb_doe_top.sv

/* doe_cipher.sv */
// ######################################
// iterative toy block cipher, one round or one key step per cycle
// not a real cipher, it only gives the flow something to decipher
// doe_init must come before the first doe_next of a flow
// ######################################
`timescale 1ns/1ns
`default_nettype none

module doe_cipher #(
    parameter int SRC_WIDTH  = 128,
    parameter int DEST_WIDTH = 128,
    parameter int NUM_ROUNDS = 4,
    localparam int DEST_DWORDS = DEST_WIDTH / 32
) (
    input  logic                              clk,
    input  logic                              hard_rst_b,
    input  doe_pkg::block_t                   obf_key,
    input  logic                              src_write_en,
    input  doe_pkg::block_t                   src_write_data,
    input  logic                              doe_init,
    input  logic                              doe_next,
    output logic                              init_done,
    output logic                              dest_data_avail,
    output doe_pkg::dword_t [DEST_DWORDS-1:0] dest_data
);
    import doe_pkg::*;

    localparam int CNT_W = (NUM_ROUNDS > 1) ? $clog2(NUM_ROUNDS) : 1;

    logic             busy;
    logic             key_mode;
    logic [CNT_W-1:0] round_cnt;
    logic             last_round;

    block_t round_key [NUM_ROUNDS];
    block_t key_work;
    block_t key_step;
    block_t src_block;
    block_t chain;
    block_t state;
    block_t round_out;

    // the key schedule counts up from key 0, deciphering counts down to key 0
    assign last_round = key_mode ? (round_cnt == CNT_W'(NUM_ROUNDS - 1)) : (round_cnt == '0);

    // each round key is the previous one rotated left by another byte
    assign key_step  = {key_work[SRC_WIDTH-9:0], key_work[SRC_WIDTH-1:SRC_WIDTH-8]};
    assign round_out = {round_key[round_cnt][6:0] ^ state[6:0],
                        round_key[round_cnt][SRC_WIDTH-1:7] ^ state[SRC_WIDTH-1:7]};

    always_ff @(posedge clk or negedge hard_rst_b) begin
        if (!hard_rst_b) begin
            busy            <= 1'b0;
            key_mode        <= 1'b0;
            round_cnt       <= '0;
            init_done       <= 1'b0;
            dest_data_avail <= 1'b0;
        end else if (doe_init || doe_next) begin
            busy            <= 1'b1;
            key_mode        <= doe_init;
            round_cnt       <= doe_init ? '0 : CNT_W'(NUM_ROUNDS - 1);
            init_done       <= 1'b0;
            dest_data_avail <= 1'b0;
        end else if (busy) begin
            round_cnt <= key_mode ? round_cnt + 1'b1 : round_cnt - 1'b1;
            if (last_round) begin
                busy            <= 1'b0;
                init_done       <= 1'b1;
                dest_data_avail <= !key_mode;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (src_write_en) begin
            src_block <= src_write_data;
        end
        if (doe_init) begin
            key_work <= obf_key;
            chain    <= '0;
        end else if (doe_next) begin
            state <= src_block;
        end else if (busy && key_mode) begin
            round_key[round_cnt] <= key_step;
            key_work             <= key_step;
        end else if (busy && last_round) begin
            // unchain, then the ciphertext just used chains into the next block
            state <= round_out ^ chain;
            chain <= src_block;
        end else if (busy) begin
            state <= round_out;
        end
    end

    always_comb begin
        for (int j = 0; j < DEST_DWORDS; j++) begin
            dest_data[j] = state[32*j +: 32];
        end
    end

endmodule

`default_nettype wire

/* doe_fsm.sv */
// ######################################
// flow sequencer between the secrets, the cipher and the key vault
// cmd and dest_sel must be held until flow_done is seen
// each command runs once per hard reset, repeats only pulse flow_done
// ######################################
`timescale 1ns/1ns
`default_nettype none

module doe_fsm #(
    parameter int SRC_WIDTH  = 128,
    parameter int DEST_WIDTH = 128,
    localparam int UDS_BLOCKS  = doe_pkg::UDS_DWORDS * 32 / SRC_WIDTH,
    localparam int FE_BLOCKS   = doe_pkg::FE_DWORDS * 32 / SRC_WIDTH,
    localparam int DEST_DWORDS = DEST_WIDTH / 32
) (
    input  logic                              clk,
    input  logic                              hard_rst_b,
    input  doe_pkg::doe_cmd_e                 cmd,
    input  doe_pkg::kv_entry_idx_t            dest_sel,
    input  doe_pkg::kv_client_mask_t          dest_valid,
    input  doe_pkg::block_t [UDS_BLOCKS-1:0]  obf_uds_seed,
    input  doe_pkg::block_t [FE_BLOCKS-1:0]   obf_field_entropy,
    input  logic                              init_done,
    input  logic                              dest_data_avail,
    input  doe_pkg::dword_t [DEST_DWORDS-1:0] dest_data,
    output logic                              src_write_en,
    output doe_pkg::block_t                   src_write_data,
    output logic                              doe_init,
    output logic                              doe_next,
    output logic                              write_en,
    output doe_pkg::kv_entry_idx_t            write_entry,
    output doe_pkg::kv_offset_t               write_offset,
    output doe_pkg::dword_t                   write_data,
    output doe_pkg::kv_client_mask_t          write_valid_mask,
    output logic                              flow_done
);
    import doe_pkg::*;

    localparam int MAX_BLOCKS = (UDS_BLOCKS > FE_BLOCKS) ? UDS_BLOCKS : FE_BLOCKS;
    localparam int BLK_W      = (MAX_BLOCKS > 1) ? $clog2(MAX_BLOCKS) : 1;
    localparam int DW_W       = (DEST_DWORDS > 1) ? $clog2(DEST_DWORDS) : 1;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT,
        ST_BLOCK,
        ST_NEXT,
        ST_WAIT,
        ST_WRITE,
        ST_DONE
    } state_e;

    state_e        state_q;
    state_e        state_d;
    logic [BLK_W-1:0] blk_off;
    kv_offset_t    wr_off;
    kv_entry_idx_t entry_q;
    logic          lock_uds;
    logic          lock_fe;
    logic          run_uds;
    logic          run_fe;
    logic          start;
    logic          last_block;
    logic          last_dword;

    assign run_uds = (cmd == DOE_CMD_UDS);
    assign run_fe  = (cmd == DOE_CMD_FE);
    assign start   = (run_uds && !lock_uds) || (run_fe && !lock_fe);

    assign last_block = run_uds ? (blk_off == BLK_W'(UDS_BLOCKS - 1))
                                : (blk_off == BLK_W'(FE_BLOCKS - 1));
    assign last_dword = (wr_off[DW_W-1:0] == DW_W'(DEST_DWORDS - 1));

    always_comb begin
        state_d      = state_q;
        src_write_en = 1'b0;
        doe_init     = 1'b0;
        doe_next     = 1'b0;
        write_en     = 1'b0;
        flow_done    = 1'b0;
        case (state_q)
            ST_IDLE: begin
                // a locked command is answered at once and never starts
                flow_done = (run_uds && lock_uds) || (run_fe && lock_fe);
                if (start) begin
                    state_d = ST_INIT;
                end
            end
            ST_INIT: begin
                doe_init = 1'b1;
                state_d  = ST_WAIT;
            end
            ST_BLOCK: begin
                src_write_en = 1'b1;
                state_d      = ST_NEXT;
            end
            ST_NEXT: begin
                doe_next = 1'b1;
                state_d  = ST_WAIT;
            end
            ST_WAIT: begin
                if (init_done && dest_data_avail) begin
                    state_d = ST_WRITE;
                end else if (init_done) begin
                    state_d = ST_BLOCK;
                end
            end
            ST_WRITE: begin
                write_en = 1'b1;
                if (last_dword) begin
                    state_d = last_block ? ST_DONE : ST_BLOCK;
                end
            end
            ST_DONE: begin
                flow_done = 1'b1;
                state_d   = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge hard_rst_b) begin
        if (!hard_rst_b) begin
            state_q  <= ST_IDLE;
            blk_off  <= '0;
            wr_off   <= '0;
            entry_q  <= '0;
            lock_uds <= 1'b0;
            lock_fe  <= 1'b0;
        end else begin
            state_q <= state_d;

            // an entry holds 16 dwords, a longer secret spills into the next one
            if (state_q == ST_IDLE && start) begin
                entry_q <= dest_sel;
            end else if (write_en && wr_off == '1) begin
                entry_q <= entry_q + 1'b1;
            end

            if (write_en) begin
                wr_off <= wr_off + 1'b1;
            end else if (state_q == ST_DONE) begin
                wr_off <= '0;
            end

            if (write_en && last_dword && !last_block) begin
                blk_off <= blk_off + 1'b1;
            end else if (state_q == ST_DONE) begin
                blk_off <= '0;
            end

            // the locks are sticky until the next hard reset
            if (state_q == ST_DONE) begin
                lock_uds <= lock_uds || run_uds;
                lock_fe  <= lock_fe || run_fe;
            end
        end
    end

    always_comb begin
        if (run_uds) begin
            src_write_data = obf_uds_seed[blk_off];
        end else if (run_fe) begin
            src_write_data = obf_field_entropy[blk_off];
        end else begin
            src_write_data = '0;
        end
    end

    // the cipher result is big endian, the vault stores the last dword first
    assign write_data       = dest_data[DW_W'(DEST_DWORDS - 1) - wr_off[DW_W-1:0]];
    assign write_entry      = entry_q;
    assign write_offset     = wr_off;
    assign write_valid_mask = dest_valid;

endmodule

`default_nettype wire

/* doe_pkg.sv */
// ######################################
// widths, typedefs and the command encoding shared by the deobfuscation
// engine and its testbench
// the UDS and FE sizes must be whole multiples of the cipher block width
// ######################################
`default_nettype none

package doe_pkg;

    // vault geometry
    localparam int KV_NUM_ENTRIES  = 8;
    localparam int KV_ENTRY_DWORDS = 16;

    // obfuscated secret sizes in dwords
    localparam int UDS_DWORDS = 16;
    localparam int FE_DWORDS  = 8;

    typedef logic [31:0]  dword_t;
    typedef logic [127:0] block_t;

    typedef logic [2:0] kv_entry_idx_t;
    typedef logic [3:0] kv_offset_t;

    // bit n of the mask lets client n read the entry
    typedef logic [1:0] kv_client_mask_t;
    typedef logic       kv_client_t;

    typedef enum logic [1:0] {
        DOE_CMD_IDLE = 2'b00,
        DOE_CMD_UDS  = 2'b01,
        DOE_CMD_FE   = 2'b10
    } doe_cmd_e;

endpackage

`default_nettype wire

/* doe_top.sv */
// ######################################
// deobfuscation engine with its eight entry key vault
// SRC_WIDTH and DEST_WIDTH must match and divide the UDS and FE sizes
// reads are combinational and see writes one cycle after they happen
// ######################################
`timescale 1ns/1ns
`default_nettype none

module doe_top #(
    parameter int SRC_WIDTH  = 128,
    parameter int DEST_WIDTH = 128,
    parameter int NUM_ROUNDS = 4,
    localparam int UDS_BLOCKS = doe_pkg::UDS_DWORDS * 32 / SRC_WIDTH,
    localparam int FE_BLOCKS  = doe_pkg::FE_DWORDS * 32 / SRC_WIDTH
) (
    input  logic                             clk,
    input  logic                             hard_rst_b,
    input  doe_pkg::block_t                  obf_key,
    input  doe_pkg::block_t [UDS_BLOCKS-1:0] obf_uds_seed,
    input  doe_pkg::block_t [FE_BLOCKS-1:0]  obf_field_entropy,
    input  doe_pkg::doe_cmd_e                cmd,
    input  doe_pkg::kv_entry_idx_t           dest_sel,
    input  doe_pkg::kv_client_mask_t         dest_valid,
    output logic                             flow_done,
    input  doe_pkg::kv_client_t              rd_client,
    input  doe_pkg::kv_entry_idx_t           rd_entry,
    input  doe_pkg::kv_offset_t              rd_offset,
    output doe_pkg::dword_t                  rd_data
);
    import doe_pkg::*;

    localparam int DEST_DWORDS = DEST_WIDTH / 32;

    logic                              src_write_en;
    block_t                            src_write_data;
    logic                              doe_init;
    logic                              doe_next;
    logic                              init_done;
    logic                              dest_data_avail;
    dword_t [DEST_DWORDS-1:0]          dest_data;

    logic                              write_en;
    kv_entry_idx_t                     write_entry;
    kv_offset_t                        write_offset;
    dword_t                            write_data;
    kv_client_mask_t                   write_valid_mask;

    dword_t [KV_NUM_ENTRIES-1:0][KV_ENTRY_DWORDS-1:0] all_entry_data;
    kv_client_mask_t [KV_NUM_ENTRIES-1:0]             all_entry_mask;

    doe_fsm #(
        .SRC_WIDTH  (SRC_WIDTH),
        .DEST_WIDTH (DEST_WIDTH)
    ) u_fsm (
        .clk               (clk),
        .hard_rst_b        (hard_rst_b),
        .cmd               (cmd),
        .dest_sel          (dest_sel),
        .dest_valid        (dest_valid),
        .obf_uds_seed      (obf_uds_seed),
        .obf_field_entropy (obf_field_entropy),
        .init_done         (init_done),
        .dest_data_avail   (dest_data_avail),
        .dest_data         (dest_data),
        .src_write_en      (src_write_en),
        .src_write_data    (src_write_data),
        .doe_init          (doe_init),
        .doe_next          (doe_next),
        .write_en          (write_en),
        .write_entry       (write_entry),
        .write_offset      (write_offset),
        .write_data        (write_data),
        .write_valid_mask  (write_valid_mask),
        .flow_done         (flow_done)
    );

    doe_cipher #(
        .SRC_WIDTH  (SRC_WIDTH),
        .DEST_WIDTH (DEST_WIDTH),
        .NUM_ROUNDS (NUM_ROUNDS)
    ) u_cipher (
        .clk             (clk),
        .hard_rst_b      (hard_rst_b),
        .obf_key         (obf_key),
        .src_write_en    (src_write_en),
        .src_write_data  (src_write_data),
        .doe_init        (doe_init),
        .doe_next        (doe_next),
        .init_done       (init_done),
        .dest_data_avail (dest_data_avail),
        .dest_data       (dest_data)
    );

    for (genvar i = 0; i < KV_NUM_ENTRIES; i++) begin : g_entry
        kv_entry #(
            .ENTRY_IDX (kv_entry_idx_t'(i))
        ) u_entry (
            .clk              (clk),
            .hard_rst_b       (hard_rst_b),
            .write_en         (write_en),
            .write_entry      (write_entry),
            .write_offset     (write_offset),
            .write_data       (write_data),
            .write_valid_mask (write_valid_mask),
            .entry_data       (all_entry_data[i]),
            .entry_mask       (all_entry_mask[i])
        );
    end

    kv_read_mux u_read_mux (
        .rd_client      (rd_client),
        .rd_entry       (rd_entry),
        .rd_offset      (rd_offset),
        .all_entry_data (all_entry_data),
        .all_entry_mask (all_entry_mask),
        .rd_data        (rd_data)
    );

endmodule

`default_nettype wire

/* kv_entry.sv */
// ######################################
// one key vault entry of 16 dwords and its client mask
// the mask is overwritten by every write to the entry
// ######################################
`timescale 1ns/1ns
`default_nettype none

module kv_entry #(
    parameter doe_pkg::kv_entry_idx_t ENTRY_IDX = '0
) (
    input  logic                                          clk,
    input  logic                                          hard_rst_b,
    input  logic                                          write_en,
    input  doe_pkg::kv_entry_idx_t                        write_entry,
    input  doe_pkg::kv_offset_t                           write_offset,
    input  doe_pkg::dword_t                               write_data,
    input  doe_pkg::kv_client_mask_t                      write_valid_mask,
    output doe_pkg::dword_t [doe_pkg::KV_ENTRY_DWORDS-1:0] entry_data,
    output doe_pkg::kv_client_mask_t                      entry_mask
);

    logic hit;

    // the write bus is shared by all entries, only the addressed one takes it
    assign hit = write_en && (write_entry == ENTRY_IDX);

    always_ff @(posedge clk or negedge hard_rst_b) begin
        if (!hard_rst_b) begin
            entry_data <= '0;
            entry_mask <= '0;
        end else if (hit) begin
            entry_data[write_offset] <= write_data;
            entry_mask               <= write_valid_mask;
        end
    end

endmodule

`default_nettype wire

/* kv_read_mux.sv */
// ######################################
// combinational vault read port
// a client without permission on the entry reads zero
// ######################################
`timescale 1ns/1ns
`default_nettype none

module kv_read_mux (
    input  doe_pkg::kv_client_t    rd_client,
    input  doe_pkg::kv_entry_idx_t rd_entry,
    input  doe_pkg::kv_offset_t    rd_offset,
    input  doe_pkg::dword_t [doe_pkg::KV_NUM_ENTRIES-1:0][doe_pkg::KV_ENTRY_DWORDS-1:0]
                                   all_entry_data,
    input  doe_pkg::kv_client_mask_t [doe_pkg::KV_NUM_ENTRIES-1:0] all_entry_mask,
    output doe_pkg::dword_t        rd_data
);

    logic allowed;

    assign allowed = all_entry_mask[rd_entry][rd_client];
    assign rd_data = allowed ? all_entry_data[rd_entry][rd_offset] : '0;

endmodule

`default_nettype wire

/* project.f */
doe_pkg.sv
doe_cipher.sv
doe_fsm.sv
kv_entry.sv
kv_read_mux.sv
doe_top.sv
tb_clkgen.sv
tb_doe_top.sv

/* tb_clkgen.sv */
// ######################################
// clock and reset source for the testbench
// reset is held low for RST_CYCLES at start of run
// and again after every rising edge on rst_req
// ######################################
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 4
) (
    input  logic rst_req,
    output logic clk,
    output logic hard_rst_b
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

    // reset is released on a falling edge, half a period away from the flops' capture edge
    initial begin
        hard_rst_b = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        hard_rst_b = 1'b1;
        forever begin
            @(posedge rst_req);
            hard_rst_b = 1'b0;
            repeat (RST_CYCLES) @(negedge clk);
            hard_rst_b = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tb_doe_top.sv */
// ######################################
// testbench for the deobfuscation engine and its key vault
// a reference model of the toy cipher predicts every vault dword
// reads are sampled 2 ns after the falling edge that drives them
// ######################################
`timescale 1ns/1ns
`default_nettype none

module tb_doe_top;
    import doe_pkg::*;

    localparam int NUM_ROUNDS   = 4;
    localparam int BLOCK_DWORDS = 4;
    localparam int UDS_BLOCKS   = UDS_DWORDS / BLOCK_DWORDS;
    localparam int FE_BLOCKS    = FE_DWORDS / BLOCK_DWORDS;
    localparam int DONE_TIMEOUT = 2000;
    localparam int RST_TIMEOUT  = 20;

    logic clk;
    logic hard_rst_b;
    logic rst_req;

    block_t                  obf_key;
    block_t [UDS_BLOCKS-1:0] obf_uds_seed;
    block_t [FE_BLOCKS-1:0]  obf_field_entropy;
    doe_cmd_e                cmd;
    kv_entry_idx_t           dest_sel;
    kv_client_mask_t         dest_valid;
    logic                    flow_done;
    kv_client_t              rd_client;
    kv_entry_idx_t           rd_entry;
    kv_offset_t              rd_offset;
    dword_t                  rd_data;

    // expected vault contents and lock state
    dword_t          exp_data [KV_NUM_ENTRIES][KV_ENTRY_DWORDS];
    kv_client_mask_t exp_mask [KV_NUM_ENTRIES];
    logic            exp_lock_uds;
    logic            exp_lock_fe;

    int seed;
    int checks;
    int errors;
    int test_errors;

    tb_clkgen #(
        .PERIOD_NS  (10),
        .RST_CYCLES (4)
    ) u_clkgen (
        .rst_req    (rst_req),
        .clk        (clk),
        .hard_rst_b (hard_rst_b)
    );

    doe_top #(
        .SRC_WIDTH  (128),
        .DEST_WIDTH (128),
        .NUM_ROUNDS (NUM_ROUNDS)
    ) DUT (
        .clk               (clk),
        .hard_rst_b        (hard_rst_b),
        .obf_key           (obf_key),
        .obf_uds_seed      (obf_uds_seed),
        .obf_field_entropy (obf_field_entropy),
        .cmd               (cmd),
        .dest_sel          (dest_sel),
        .dest_valid        (dest_valid),
        .flow_done         (flow_done),
        .rd_client         (rd_client),
        .rd_entry          (rd_entry),
        .rd_offset         (rd_offset),
        .rd_data           (rd_data)
    );

    function automatic block_t rotate_left(input block_t v, input int n);
        return (v << n) | (v >> (128 - n));
    endfunction

    function automatic block_t rotate_right(input block_t v, input int n);
        return (v >> n) | (v << (128 - n));
    endfunction

    function automatic block_t random_block();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic clear_model();
        for (int e = 0; e < KV_NUM_ENTRIES; e++) begin
            exp_mask[e] = '0;
            for (int o = 0; o < KV_ENTRY_DWORDS; o++) begin
                exp_data[e][o] = '0;
            end
        end
        exp_lock_uds = 1'b0;
        exp_lock_fe  = 1'b0;
    endtask

    task automatic draw_secrets();
        @(negedge clk);
        obf_key = random_block();
        for (int b = 0; b < UDS_BLOCKS; b++) begin
            obf_uds_seed[b] = random_block();
        end
        for (int b = 0; b < FE_BLOCKS; b++) begin
            obf_field_entropy[b] = random_block();
        end
    endtask

    // deciphers the selected secret and places the dwords the way the vault should hold them
    task automatic predict_flow(input doe_cmd_e c, input kv_entry_idx_t sel,
                                input kv_client_mask_t mask);
        block_t        round_key [NUM_ROUNDS];
        block_t        chain;
        block_t        src;
        block_t        st;
        int            nblk;
        int            d;
        kv_entry_idx_t e;
        if ((c == DOE_CMD_UDS && exp_lock_uds) || (c == DOE_CMD_FE && exp_lock_fe)) begin
            return;
        end
        for (int i = 0; i < NUM_ROUNDS; i++) begin
            round_key[i] = rotate_left(obf_key, 8 * (i + 1));
        end
        chain = '0;
        nblk  = (c == DOE_CMD_UDS) ? UDS_BLOCKS : FE_BLOCKS;
        for (int b = 0; b < nblk; b++) begin
            if (c == DOE_CMD_UDS) begin
                src = obf_uds_seed[b];
            end else begin
                src = obf_field_entropy[b];
            end
            st = src;
            for (int i = NUM_ROUNDS - 1; i >= 0; i--) begin
                st = rotate_right(st ^ round_key[i], 7);
            end
            st    = st ^ chain;
            chain = src;
            for (int k = 0; k < BLOCK_DWORDS; k++) begin
                d = BLOCK_DWORDS * b + k;
                e = kv_entry_idx_t'(sel + d / KV_ENTRY_DWORDS);
                exp_data[e][d % KV_ENTRY_DWORDS] = st[32 * (BLOCK_DWORDS - 1 - k) +: 32];
                exp_mask[e] = mask;
            end
        end
        if (c == DOE_CMD_UDS) begin
            exp_lock_uds = 1'b1;
        end else begin
            exp_lock_fe = 1'b1;
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!hard_rst_b && cycles < RST_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        checks++;
        assert (hard_rst_b) else begin
            $display("reset was still asserted after %0d cycles", RST_TIMEOUT);
            errors++;
        end
    endtask

    task automatic run_command(input doe_cmd_e c, input kv_entry_idx_t sel,
                               input kv_client_mask_t mask);
        int   cycles;
        logic seen;
        predict_flow(c, sel, mask);
        @(negedge clk);
        cmd        = c;
        dest_sel   = sel;
        dest_valid = mask;
        seen       = 1'b0;
        cycles     = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            seen = flow_done;
            cycles++;
        end
        checks++;
        assert (seen) else begin
            $display("flow_done did not rise within %0d cycles of the command", DONE_TIMEOUT);
            errors++;
        end
        // the FSM records the lock on the clock edge that ends its done cycle
        @(negedge clk);
        cmd = DOE_CMD_IDLE;
    endtask

    task automatic check_read(input kv_client_t c, input kv_entry_idx_t e, input kv_offset_t o);
        dword_t expected;
        expected = exp_mask[e][c] ? exp_data[e][o] : '0;
        @(negedge clk);
        rd_client = c;
        rd_entry  = e;
        rd_offset = o;
        #2;
        checks++;
        assert (rd_data == expected) else begin
            $display("FAIL rd_data client %0d entry %0d offset %0d: expected %h, got %h",
                     c, e, o, expected, rd_data);
            errors++;
        end
    endtask

    task automatic check_vault();
        for (int e = 0; e < KV_NUM_ENTRIES; e++) begin
            for (int o = 0; o < KV_ENTRY_DWORDS; o++) begin
                check_read(1'b0, kv_entry_idx_t'(e), kv_offset_t'(o));
                check_read(1'b1, kv_entry_idx_t'(e), kv_offset_t'(o));
            end
        end
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        seed              = 32'h703e;
        checks            = 0;
        errors            = 0;
        test_errors       = 0;
        rst_req           = 1'b0;
        obf_key           = '0;
        obf_uds_seed      = '0;
        obf_field_entropy = '0;
        cmd               = DOE_CMD_IDLE;
        dest_sel          = '0;
        dest_valid        = '0;
        rd_client         = '0;
        rd_entry          = '0;
        rd_offset         = '0;
        clear_model();
        wait_reset_release();
        draw_secrets();

        run_command(DOE_CMD_UDS, 3'd2, 2'b01);
        check_vault();
        end_test(1, "uds flow");

        run_command(DOE_CMD_FE, 3'd7, 2'b10);
        check_vault();
        end_test(2, "fe flow");

        // both commands have run, so these must be refused without writes
        run_command(DOE_CMD_UDS, 3'd4, 2'b11);
        run_command(DOE_CMD_FE, 3'd5, 2'b11);
        check_vault();
        end_test(3, "locks");

        // a locked command held into reset is no longer answered once the locks clear
        @(negedge clk);
        cmd     = DOE_CMD_FE;
        rst_req = 1'b1;
        clear_model();
        @(negedge clk);
        rst_req = 1'b0;
        checks++;
        assert (flow_done == 1'b0) else begin
            $display("FAIL flow_done in reset: expected %h, got %h", 1'b0, flow_done);
            errors++;
        end
        cmd = DOE_CMD_IDLE;
        wait_reset_release();
        check_vault();
        draw_secrets();
        run_command(DOE_CMD_UDS, 3'd4, 2'b11);
        check_vault();
        end_test(4, "reset");

        // destination inputs wander while no command is given
        for (int n = 0; n < 50; n++) begin
            @(negedge clk);
            checks++;
            assert (flow_done == 1'b0) else begin
                $display("FAIL flow_done while idle: expected %h, got %h", 1'b0, flow_done);
                errors++;
            end
            dest_sel   = kv_entry_idx_t'($random(seed));
            dest_valid = kv_client_mask_t'($random(seed));
        end
        check_vault();
        end_test(5, "idle stability");

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
